/* logic/sensor_pkg.sv */
// Signal path types shared by the transform, energy and scan stages
// Transform words hold three Haar levels of 4-bit samples without overflow

package sensor_pkg;

    // ========================================================================
    // Widths
    // ========================================================================
    // Raw ADC sample, two's complement
    localparam int ADC_BITS    = 4;
    // Signed transform word
    localparam int COEF_BITS   = 12;
    localparam int NUM_BANDS   = 8;
    // Band energy after saturation
    localparam int ENERGY_BITS = 16;

    // ========================================================================
    // Types
    // ========================================================================
    typedef logic [ADC_BITS-1:0]          sample_t;
    typedef logic signed [COEF_BITS-1:0]  coef_t;
    typedef logic [ENERGY_BITS-1:0]       energy_t;
    // Band number, also used as the sample buffer index
    typedef logic [$clog2(NUM_BANDS)-1:0] band_idx_t;

endpackage

/* logic/link_pkg.sv */
// Uplink packet layout and pass sequencing definitions
// Packet is fixed at 14 bits around a 3-bit command

package link_pkg;

    // Command sent uplink, equal to the winning band number
    typedef logic [2:0] cmd_t;

    // ========================================================================
    // Packet fields in send order, MSB first
    // ========================================================================
    localparam int         PACKET_BITS = 14;
    localparam logic [3:0] PREAMBLE    = 4'b1010;
    localparam logic [3:0] SYNC_WORD   = 4'b1100;
    // Command and its parity sit between sync and postamble
    localparam logic [1:0] POSTAMBLE   = 2'b11;

    // ========================================================================
    // Sequencer states, one pass from wake to sleep
    // ========================================================================
    typedef enum logic [3:0] {
        S_IDLE, S_WAKE,
        S_DWT, S_WAIT_DWT,
        S_ENERGY, S_WAIT_ENERGY,
        S_ENCODE,
        S_TX, S_TX_ACK, S_TX_WAIT,
        S_SLEEP
    } seq_state_t;

endpackage

/* logic/band_if.sv */
// Subbands and band energies shared by the data stages
// Each array holds its contents until its producer runs again
`timescale 1ns/1ns

interface band_if;
    import sensor_pkg::*;

    // Haar subbands, band 0 is the level-3 approximation
    coef_t   sub    [NUM_BANDS];
    // Saturated squares of the subband magnitudes
    energy_t energy [NUM_BANDS];

    // Transform writes the subbands
    modport dwt_mp    (output sub);
    // Energy stage reads subbands and writes energies
    modport energy_mp (input sub, output energy);
    // Peak scan only looks at the energies
    modport scan_mp   (input energy);

endinterface

/* logic/lsk_bit_timer.sv */
// Cycle counter within one Manchester bit
// BIT_PERIOD must be even and at least 4
`timescale 1ns/1ns

module lsk_bit_timer #(
    parameter int BIT_PERIOD = 200
) (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic second_half,
    output logic bit_end
);

    localparam int CNT_BITS = $clog2(BIT_PERIOD);

    logic [CNT_BITS-1:0] cnt;

    // Held at zero while idle, wraps at the end of each bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!run || bit_end) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Second half starts at BIT_PERIOD/2
    assign second_half = (cnt >= CNT_BITS'(BIT_PERIOD / 2));
    assign bit_end     = (cnt == CNT_BITS'(BIT_PERIOD - 1));

endmodule

/* logic/manchester_tx.sv */
// 14-bit Manchester uplink, data in the first half of each bit, inverse in the second
// tx_active lasts exactly 14 x BIT_PERIOD cycles starting one cycle after tx_start
`timescale 1ns/1ns

module manchester_tx #(
    parameter int BIT_PERIOD = 200
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           tx_start,
    input  link_pkg::cmd_t cmd_in,
    output logic           lsk_ctrl,
    output logic           tx_active
);
    import link_pkg::*;

    localparam int IDX_BITS = $clog2(PACKET_BITS);

    logic [PACKET_BITS-1:0] packet;
    logic [IDX_BITS-1:0]    bit_idx;
    logic                   second_half;
    logic                   bit_end;

    lsk_bit_timer #(
        .BIT_PERIOD (BIT_PERIOD)
    ) u_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (tx_active),
        .second_half (second_half),
        .bit_end     (bit_end)
    );

    // Packet latched once per send, parity is XOR of the command
    always_ff @(posedge clk) begin
        if (tx_start) begin
            packet <= {PREAMBLE, SYNC_WORD, cmd_in, ^cmd_in, POSTAMBLE};
        end
    end

    // Bit index walks down from the MSB, last bit ends the send
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_active <= 1'b0;
            bit_idx   <= '0;
        end else if (tx_start) begin
            tx_active <= 1'b1;
            bit_idx   <= IDX_BITS'(PACKET_BITS - 1);
        end else if (tx_active && bit_end) begin
            if (bit_idx == '0) begin
                tx_active <= 1'b0;
            end else begin
                bit_idx <= bit_idx - 1'b1;
            end
        end
    end

    // Line is quiet whenever nothing is being sent
    assign lsk_ctrl = tx_active & (packet[bit_idx] ^ second_half);

endmodule

/* logic/wake_sequencer.sv */
// Steps one processing pass per wake level
// A wake level still high after sleep starts another pass
// Stages are trusted to answer, there is no timeout
`timescale 1ns/1ns

module wake_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic wake,
    input  logic dwt_done,
    input  logic energy_done,
    input  logic cmd_valid,
    input  logic tx_active,
    output logic dwt_start,
    output logic energy_start,
    output logic encode_start,
    output logic tx_start,
    output logic pwr_gate_ctrl
);
    import link_pkg::*;

    logic       wake_meta;
    logic       wake_sync;
    seq_state_t state;
    seq_state_t next_state;

    // Two-flop synchronizer for the asynchronous wake level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wake_meta <= 1'b0;
            wake_sync <= 1'b0;
        end else begin
            wake_meta <= wake;
            wake_sync <= wake_meta;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ========================================================================
    // Next state
    // ========================================================================
    always_comb begin
        next_state = state;
        case (state)
            S_IDLE:        if (wake_sync)   next_state = S_WAKE;
            S_WAKE:                         next_state = S_DWT;
            S_DWT:                          next_state = S_WAIT_DWT;
            S_WAIT_DWT:    if (dwt_done)    next_state = S_ENERGY;
            S_ENERGY:                       next_state = S_WAIT_ENERGY;
            S_WAIT_ENERGY: if (energy_done) next_state = S_ENCODE;
            // Scan runs inside S_ENCODE until the command appears
            S_ENCODE:      if (cmd_valid)   next_state = S_TX;
            S_TX:                           next_state = S_TX_ACK;
            // tx_start is seen here, tx_active rises next cycle
            S_TX_ACK:                       next_state = S_TX_WAIT;
            S_TX_WAIT:     if (!tx_active)  next_state = S_SLEEP;
            S_SLEEP:                        next_state = S_IDLE;
            default:                        next_state = S_IDLE;
        endcase
    end

    // Registered start strobes, each high for one cycle on entry to its step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dwt_start    <= 1'b0;
            energy_start <= 1'b0;
            encode_start <= 1'b0;
            tx_start     <= 1'b0;
        end else begin
            dwt_start    <= (state == S_WAKE);
            energy_start <= (state == S_WAIT_DWT) && dwt_done;
            encode_start <= (state == S_WAIT_ENERGY) && energy_done;
            tx_start     <= (state == S_TX);
        end
    end

    // Power stays on for the whole pass
    assign pwr_gate_ctrl = (state != S_IDLE) && (state != S_SLEEP);

endmodule

/* logic/haar_dwt.sv */
// Sample capture and three-level Haar lifting over an 8-entry circular buffer
// Samples keep landing in the buffer during a transform, nothing holds them off
// Subbands and dwt_done appear 4 cycles after dwt_start
`timescale 1ns/1ns

module haar_dwt (
    input  logic                clk,
    input  logic                rst_n,
    input  sensor_pkg::sample_t adc_data,
    input  logic                adc_valid,
    input  logic                dwt_start,
    output logic                dwt_done,
    band_if.dwt_mp              bands
);
    import sensor_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_L1, ST_L2, ST_L3} step_t;

    logic      valid_meta;
    logic      valid_sync;
    band_idx_t wr_ptr;
    step_t     step;
    coef_t     sample_ext;
    coef_t     buf_r [NUM_BANDS];
    // Level-1 and level-2 approximations and details
    coef_t     a1 [4];
    coef_t     d1 [4];
    coef_t     a2 [2];
    coef_t     d2 [2];

    // Lifting approximation, even plus half the detail
    function automatic coef_t lift_approx(coef_t even_w, coef_t odd_w);
        coef_t detail;
        detail = odd_w - even_w;
        return even_w + (detail >>> 1);
    endfunction

    assign sample_ext = {{(COEF_BITS-ADC_BITS){adc_data[ADC_BITS-1]}}, adc_data};

    // ========================================================================
    // Control
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_meta <= 1'b0;
            valid_sync <= 1'b0;
            wr_ptr     <= '0;
            step       <= ST_IDLE;
            dwt_done   <= 1'b0;
        end else begin
            valid_meta <= adc_valid;
            valid_sync <= valid_meta;
            // Pointer wraps on its own, only reset clears it
            if (valid_sync) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            dwt_done <= (step == ST_L3);
            case (step)
                ST_IDLE: if (dwt_start) step <= ST_L1;
                ST_L1:   step <= ST_L2;
                ST_L2:   step <= ST_L3;
                default: step <= ST_IDLE;
            endcase
        end
    end

    // ========================================================================
    // Buffer and lifting datapath
    // ========================================================================
    always_ff @(posedge clk) begin
        if (valid_sync) begin
            buf_r[wr_ptr] <= sample_ext;
        end
        case (step)
            // Level 1 on buffer pairs (0,1) (2,3) (4,5) (6,7)
            ST_L1: begin
                for (int i = 0; i < 4; i++) begin
                    d1[i] <= buf_r[2*i+1] - buf_r[2*i];
                    a1[i] <= lift_approx(buf_r[2*i], buf_r[2*i+1]);
                end
            end
            ST_L2: begin
                for (int i = 0; i < 2; i++) begin
                    d2[i] <= a1[2*i+1] - a1[2*i];
                    a2[i] <= lift_approx(a1[2*i], a1[2*i+1]);
                end
            end
            // Level 3 and publish all eight bands at once
            ST_L3: begin
                bands.sub[0] <= lift_approx(a2[0], a2[1]);
                bands.sub[1] <= a2[1] - a2[0];
                bands.sub[2] <= d2[0];
                bands.sub[3] <= d2[1];
                for (int i = 0; i < 4; i++) begin
                    bands.sub[4+i] <= d1[i];
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* logic/band_energy.sv */
// Band energy through one shared multiplier, one band per cycle
// Energy is the square of |subband| clipped at 65535
// energy_done pulses 9 cycles after energy_start
`timescale 1ns/1ns

module band_energy (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      energy_start,
    output logic      energy_done,
    band_if.energy_mp bands
);
    import sensor_pkg::*;

    logic                   running;
    band_idx_t              idx;
    coef_t                  cur;
    logic [COEF_BITS-1:0]   mag;
    logic [2*COEF_BITS-1:0] square;
    energy_t                square_sat;

    // Magnitude of the band in turn, -2048 still fits unsigned
    assign cur        = bands.sub[idx];
    assign mag        = cur[COEF_BITS-1] ? -cur : cur;
    assign square     = mag * mag;
    // Clip anything beyond 16 bits
    assign square_sat = (|square[2*COEF_BITS-1:ENERGY_BITS]) ? '1 : square[ENERGY_BITS-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running     <= 1'b0;
            idx         <= '0;
            energy_done <= 1'b0;
        end else begin
            energy_done <= running && (idx == band_idx_t'(NUM_BANDS - 1));
            if (energy_start) begin
                running <= 1'b1;
                idx     <= '0;
            end else if (running) begin
                if (idx == band_idx_t'(NUM_BANDS - 1)) begin
                    running <= 1'b0;
                end
                idx <= idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (running) begin
            bands.energy[idx] <= square_sat;
        end
    end

endmodule

/* logic/peak_band_encoder.sv */
// Sequential argmax over the band energies
// Ties keep the lower band number, cmd_valid pulses 9 cycles after encode_start
`timescale 1ns/1ns

module peak_band_encoder (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           encode_start,
    output link_pkg::cmd_t cmd_out,
    output logic           cmd_valid,
    band_if.scan_mp        bands
);
    import sensor_pkg::*;

    logic      scanning;
    logic      publish;
    band_idx_t scan_idx;
    energy_t   max_energy;
    band_idx_t max_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scanning   <= 1'b0;
            publish    <= 1'b0;
            scan_idx   <= '0;
            max_energy <= '0;
            max_idx    <= '0;
            cmd_out    <= '0;
            cmd_valid  <= 1'b0;
        end else begin
            // One cycle after the last compare the winner goes out
            publish   <= scanning && (scan_idx == band_idx_t'(NUM_BANDS - 1));
            cmd_valid <= publish;
            if (publish) begin
                cmd_out <= max_idx;
            end
            // Band 0 seeds the running maximum
            if (encode_start) begin
                scanning   <= 1'b1;
                scan_idx   <= band_idx_t'(1);
                max_energy <= bands.energy[0];
                max_idx    <= '0;
            end else if (scanning) begin
                // Strictly greater only
                if (bands.energy[scan_idx] > max_energy) begin
                    max_energy <= bands.energy[scan_idx];
                    max_idx    <= scan_idx;
                end
                if (scan_idx == band_idx_t'(NUM_BANDS - 1)) begin
                    scanning <= 1'b0;
                end
                scan_idx <= scan_idx + 1'b1;
            end
        end
    end

endmodule

/* logic/sensor_top.sv */
// Field sensor core, sampling through uplink
// BIT_PERIOD is the uplink bit length in cycles and must be even and at least 4
// adc_valid and wake are asynchronous and synchronized inside
`timescale 1ns/1ns

module sensor_top #(
    parameter int BIT_PERIOD = 200
) (
    input  logic                clk,
    input  logic                rst_n,
    input  sensor_pkg::sample_t adc_data,
    input  logic                adc_valid,
    input  logic                wake,
    output link_pkg::cmd_t      cmd_out,
    output logic                cmd_valid,
    output logic                lsk_ctrl,
    output logic                lsk_tx,
    output logic                pwr_gate_ctrl
);

    // Sequencer strobes and the answers from each stage
    logic dwt_start;
    logic dwt_done;
    logic energy_start;
    logic energy_done;
    logic encode_start;
    logic tx_start;

    // Subbands and energies between the data stages
    band_if u_bands ();

    wake_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .wake          (wake),
        .dwt_done      (dwt_done),
        .energy_done   (energy_done),
        .cmd_valid     (cmd_valid),
        .tx_active     (lsk_tx),
        .dwt_start     (dwt_start),
        .energy_start  (energy_start),
        .encode_start  (encode_start),
        .tx_start      (tx_start),
        .pwr_gate_ctrl (pwr_gate_ctrl)
    );

    haar_dwt u_dwt (
        .clk       (clk),
        .rst_n     (rst_n),
        .adc_data  (adc_data),
        .adc_valid (adc_valid),
        .dwt_start (dwt_start),
        .dwt_done  (dwt_done),
        .bands     (u_bands.dwt_mp)
    );

    band_energy u_energy (
        .clk          (clk),
        .rst_n        (rst_n),
        .energy_start (energy_start),
        .energy_done  (energy_done),
        .bands        (u_bands.energy_mp)
    );

    peak_band_encoder u_peak (
        .clk          (clk),
        .rst_n        (rst_n),
        .encode_start (encode_start),
        .cmd_out      (cmd_out),
        .cmd_valid    (cmd_valid),
        .bands        (u_bands.scan_mp)
    );

    // lsk_tx is the transmitter's active level
    manchester_tx #(
        .BIT_PERIOD (BIT_PERIOD)
    ) u_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_start  (tx_start),
        .cmd_in    (cmd_out),
        .lsk_ctrl  (lsk_ctrl),
        .tx_active (lsk_tx)
    );

endmodule

/* testbench/tb_clock_gen.sv */
// Free-running testbench clock and active-low reset
// Reset releases on a falling edge after RESET_CYCLES rising edges
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // Release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* testbench/tb_sensor_top.sv */
// Directed testbench for the sensor core with BIT_PERIOD shortened to 16
// A reference model mirrors the sample buffer and derives command and packet
// Samples are spaced 4 cycles apart and never driven while a pass runs
`timescale 1ns/1ns

module tb_sensor_top;

    localparam int CLK_PERIOD   = 100;
    localparam int BIT_PERIOD   = 16;
    localparam int PACKET_BITS  = 14;
    localparam int RESET_CYCLES = 4;
    // Reset check, directed, constant, wrap and five random passes
    localparam int NUM_TESTS    = 9;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + NUM_TESTS * (PACKET_BITS * BIT_PERIOD + 60);

    logic       clk;
    logic       rst_n;
    logic [3:0] adc_data;
    logic       adc_valid;
    logic       wake;
    logic [2:0] cmd_out;
    logic       cmd_valid;
    logic       lsk_ctrl;
    logic       lsk_tx;
    logic       pwr_gate_ctrl;

    // Reference copy of the circular buffer and its write pointer
    int         model_buf [8];
    int         model_ptr;
    logic [7:0] lfsr_state;

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) clk_gen0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    sensor_top #(
        .BIT_PERIOD (BIT_PERIOD)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .adc_data      (adc_data),
        .adc_valid     (adc_valid),
        .wake          (wake),
        .cmd_out       (cmd_out),
        .cmd_valid     (cmd_valid),
        .lsk_ctrl      (lsk_ctrl),
        .lsk_tx        (lsk_tx),
        .pwr_gate_ctrl (pwr_gate_ctrl)
    );

    // ========================================================================
    // Failure handling and checks
    // ========================================================================
    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0d actual %0d", what, expected, actual);
            abort_run();
        end
    endtask

    // ========================================================================
    // Stimulus helpers
    // ========================================================================
    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // One LFSR step per sample bit
    task automatic draw_sample(output logic [3:0] s);
        s = '0;
        for (int b = 0; b < 4; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            s = {s[2:0], lfsr_state[0]};
        end
    endtask

    // Data held 4 cycles, strobe 1 cycle, written after the synchronizer
    task automatic push_sample(input logic [3:0] s);
        adc_data  = s;
        adc_valid = 1'b1;
        @(negedge clk);
        adc_valid = 1'b0;
        repeat (3) @(negedge clk);
        model_buf[model_ptr] = $signed(s);
        model_ptr = (model_ptr + 1) % 8;
    endtask

    // ========================================================================
    // Reference model
    // ========================================================================
    // Haar subbands, squared magnitudes, then argmax with low-index ties
    function automatic int predict_command();
        int a1 [4];
        int d1 [4];
        int a2 [2];
        int d2 [2];
        int band [8];
        int mag;
        int energy;
        int best_energy;
        int best;
        for (int i = 0; i < 4; i++) begin
            d1[i] = model_buf[2*i+1] - model_buf[2*i];
            a1[i] = model_buf[2*i] + (d1[i] >>> 1);
        end
        for (int i = 0; i < 2; i++) begin
            d2[i] = a1[2*i+1] - a1[2*i];
            a2[i] = a1[2*i] + (d2[i] >>> 1);
        end
        band[1] = a2[1] - a2[0];
        band[0] = a2[0] + (band[1] >>> 1);
        band[2] = d2[0];
        band[3] = d2[1];
        for (int i = 0; i < 4; i++) begin
            band[4+i] = d1[i];
        end
        best = 0;
        best_energy = -1;
        for (int i = 0; i < 8; i++) begin
            mag    = (band[i] < 0) ? -band[i] : band[i];
            energy = (mag * mag > 65535) ? 65535 : mag * mag;
            // Strictly greater so the lower band keeps a tie
            if (energy > best_energy) begin
                best_energy = energy;
                best = i;
            end
        end
        return best;
    endfunction

    // Preamble, sync, command, parity, postamble
    function automatic logic [13:0] build_packet(input logic [2:0] c);
        return {4'b1010, 4'b1100, c, c[2] ^ c[1] ^ c[0], 2'b11};
    endfunction

    // ========================================================================
    // One wake pass with command, packet and power checks
    // ========================================================================
    task automatic run_pass(input string name, input int expect_cmd);
        logic [13:0] packet;
        int          wait_cnt;
        int          bit_pos;
        packet = build_packet(expect_cmd[2:0]);
        // Two cycles is enough for the wake synchronizer
        wake = 1'b1;
        repeat (2) @(negedge clk);
        wake = 1'b0;
        wait_cnt = 0;
        while (!cmd_valid) begin
            wait_cnt++;
            if (wait_cnt > 100) begin
                $display("ERROR: %s: cmd_valid never pulsed after wake", name);
                abort_run();
            end
            @(negedge clk);
        end
        compare({name, " cmd_out"}, expect_cmd, cmd_out);
        compare({name, " pwr_gate_ctrl at cmd_valid"}, 1, pwr_gate_ctrl);
        wait_cnt = 0;
        while (!lsk_tx) begin
            wait_cnt++;
            if (wait_cnt > 20) begin
                $display("ERROR: %s: lsk_tx never rose after cmd_valid", name);
                abort_run();
            end
            @(negedge clk);
        end
        // k is the cycle count since lsk_tx rose
        for (int k = 0; k < PACKET_BITS * BIT_PERIOD; k++) begin
            bit_pos = PACKET_BITS - 1 - k / BIT_PERIOD;
            compare({name, " lsk_tx high"}, 1, lsk_tx);
            compare({name, " pwr_gate_ctrl during tx"}, 1, pwr_gate_ctrl);
            if (k % BIT_PERIOD == BIT_PERIOD / 4) begin
                compare($sformatf("%s packet bit %0d", name, bit_pos),
                        packet[bit_pos], lsk_ctrl);
            end
            if (k % BIT_PERIOD == 3 * BIT_PERIOD / 4) begin
                compare($sformatf("%s second half of bit %0d", name, bit_pos),
                        !packet[bit_pos], lsk_ctrl);
            end
            @(negedge clk);
        end
        compare({name, " lsk_tx after packet"}, 0, lsk_tx);
        repeat (3) @(negedge clk);
        compare({name, " pwr_gate_ctrl after tx"}, 0, pwr_gate_ctrl);
    endtask

    // ========================================================================
    // Tests
    // ========================================================================
    task automatic reset_quiet();
        compare("reset_quiet cmd_out", 0, cmd_out);
        repeat (50) begin
            compare("reset_quiet cmd_valid", 0, cmd_valid);
            compare("reset_quiet lsk_tx", 0, lsk_tx);
            compare("reset_quiet lsk_ctrl", 0, lsk_ctrl);
            compare("reset_quiet pwr_gate_ctrl", 0, pwr_gate_ctrl);
            @(negedge clk);
        end
    endtask

    // Strong odd-pair detail in band 6
    task automatic chosen_band();
        logic [3:0] samples [8];
        samples = '{4'h2, 4'hD, 4'h7, 4'h7, 4'h8, 4'h5, 4'h0, 4'h1};
        for (int i = 0; i < 8; i++) begin
            push_sample(samples[i]);
        end
        run_pass("chosen_band", predict_command());
    endtask

    // All details zero so band 0 wins or ties low
    task automatic constant_samples();
        repeat (8) push_sample(4'h3);
        run_pass("constant", 0);
    endtask

    // 11 samples carry the pointer past the end to entry 3
    task automatic buffer_wrap();
        for (int i = 0; i < 11; i++) begin
            push_sample(4'(i * 7 + 3));
        end
        run_pass("buffer_wrap", predict_command());
    endtask

    task automatic random_passes();
        logic [3:0] s;
        for (int p = 0; p < 5; p++) begin
            repeat (8) begin
                draw_sample(s);
                push_sample(s);
            end
            run_pass($sformatf("random_%0d", p), predict_command());
        end
    endtask

    // ========================================================================
    // Main sequence and watchdog
    // ========================================================================
    initial begin
        adc_data   = '0;
        adc_valid  = 1'b0;
        wake       = 1'b0;
        model_ptr  = 0;
        lfsr_state = 8'd59;
        for (int i = 0; i < 8; i++) begin
            model_buf[i] = 0;
        end
        wait (rst_n);
        @(negedge clk);
        reset_quiet();
        chosen_band();
        constant_samples();
        buffer_wrap();
        random_passes();
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired before the tests finished");
        abort_run();
    end

endmodule

/* project.f */
logic/sensor_pkg.sv
logic/link_pkg.sv
logic/band_if.sv
logic/lsk_bit_timer.sv
logic/manchester_tx.sv
logic/wake_sequencer.sv
logic/haar_dwt.sv
logic/band_energy.sv
logic/peak_band_encoder.sv
logic/sensor_top.sv
testbench/tb_clock_gen.sv
testbench/tb_sensor_top.sv

/* Makefile */
# Verilator build and run for the sensor core testbench
VERILATOR ?= verilator
TOP       ?= tb_sensor_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only when the pass line appears in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
